// File: list.f
logic/core_pkg.sv
logic/ctrl_demux.sv
logic/resp_mux.sv
logic/ctrl_proc.sv
logic/core_settings.sv
logic/pps_select.sv
logic/b200_core.sv
bench/tb_b200_core.sv

// File: bench/tb_b200_core.sv
// Random two-word control packets checked against a model of routing, settings and readback.
// Radio 0 is emulated by echoing each control packet back with SID 8'h11.
// Lock bits change only while no local packet is in flight.
`timescale 1ns/1ns

module tb_b200_core import core_pkg::*; ();

    localparam int   NUM_RAND       = 120;
    localparam int   NUM_PKTS       = NUM_RAND + 7;     // Plus the directed writes
    localparam int   TIMEOUT_CYCLES = NUM_PKTS * 40 + 4 * PPS_PERIOD_CYCLES;
    localparam sid_t R0_RESP_SID    = 8'h11;

    logic        radio_clk;
    logic        bus_rst;
    ctrl_word_t  i_ctrl_tdata;
    logic        i_ctrl_tlast, i_ctrl_tvalid, o_ctrl_tready;
    ctrl_word_t  o_resp_tdata;
    logic        o_resp_tlast, o_resp_tvalid, i_resp_tready;
    ctrl_word_t  o_r0_ctrl_tdata;
    logic        o_r0_ctrl_tlast, o_r0_ctrl_tvalid, i_r0_ctrl_tready;
    ctrl_word_t  i_r0_resp_tdata;
    logic        i_r0_resp_tlast, i_r0_resp_tvalid, o_r0_resp_tready;
    logic        i_pps_int, i_pps_ext, o_pps;
    logic [1:0]  i_lock_signals;
    set_data_t   i_rb_misc, o_misc_outs;

    integer      seed;
    ctrl_word_t  exp_local[$];      // Expected response words per source
    ctrl_word_t  exp_radio[$];
    ctrl_word_t  exp_r0[$];         // Expected on o_r0_ctrl
    ctrl_word_t  ret_q[$];          // Radio replies not yet returned
    ctrl_word_t  pkt_hdr[NUM_RAND];
    ctrl_word_t  pkt_cmd[NUM_RAND];
    logic [1:0]  pkt_lock[NUM_RAND];
    logic [63:0] ext_bits, gps_bits;
    set_data_t   m_misc;            // Register mirror
    rb_sel_t     m_rb_sel;
    logic [7:0]  m_gpsdo;
    logic        rx_in_pkt, rx_radio, r0_in_pkt;
    logic        ret_last, ret_taken;

    b200_core i_b200_core (.*);

    initial radio_clk = 1'b0;
    always #10 radio_clk = !radio_clk;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input ctrl_word_t got, input ctrl_word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: time %0t, %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input set_data_t got, input set_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: time %0t, %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: time %0t, %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_pps(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: time %0t, %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model
    ////////////////////////////////////////////////////////////////////////////
    task automatic update_model(input set_addr_t addr, input set_data_t data);
        case (addr)
            SR_CORE_MISC:     m_misc   = data;
            SR_CORE_READBACK: m_rb_sel = data[1:0];
            SR_CORE_GPSDO_ST: m_gpsdo  = data[7:0];
            default: ;                              // PPS select is checked on o_pps
        endcase
    endtask

    function automatic ctrl_word_t model_readback();
        case (m_rb_sel)
            2'd0:    return {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1:    return {16'h0, RADIO_STATUS, m_gpsdo, i_rb_misc};
            2'd2:    return {62'h0, i_lock_signals};
            default: return {32'h0, m_misc};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////////////////////
    task automatic send_word(input ctrl_word_t w, input logic last);
        i_ctrl_tdata  = w;
        i_ctrl_tlast  = last;
        i_ctrl_tvalid = 1'b1;
        @(negedge radio_clk);
        while (!o_ctrl_tready) @(negedge radio_clk);
        @(posedge radio_clk);                       // Word taken on this edge
        #2;
        i_ctrl_tvalid = 1'b0;
    endtask

    task automatic wait_local_idle();
        while (exp_local.size() != 0) begin
            @(posedge radio_clk);
            #2;
        end
    endtask

    task automatic wait_all_idle();
        while (exp_local.size() + exp_radio.size() + exp_r0.size() + ret_q.size() != 0) begin
            @(posedge radio_clk);
            #2;
        end
    endtask

    task automatic send_pkt(input ctrl_word_t hdr, input ctrl_word_t cmd, input logic [1:0] lock);
        if ((hdr[7:0] & SID_MASK) == R0_CTRL_SID) begin
            exp_r0.push_back(hdr);
            exp_r0.push_back(cmd);
            exp_radio.push_back({hdr[63:8], R0_RESP_SID});
            exp_radio.push_back(cmd);
        end else begin
            wait_local_idle();
            if (lock != i_lock_signals) begin
                i_lock_signals = lock;
                repeat (4) @(posedge radio_clk);    // Settle through the synchroniser
                #2;
            end
            update_model(cmd[39:32], cmd[31:0]);
            exp_local.push_back(hdr);
            exp_local.push_back(model_readback());
        end
        send_word(hdr, 1'b0);
        send_word(cmd, 1'b1);
    endtask

    // Selects a PPS source, then follows o_pps against the inputs
    task automatic run_pps(input pps_src_t src);
        int first;
        send_pkt({56'h0, L0_CTRL_SID}, {24'h0, SR_CORE_PPS_SEL, 30'h0, src}, i_lock_signals);
        wait_local_idle();
        first = -1;
        if (src == PPS_INT) begin
            for (int i = 0; i < 2 * PPS_PERIOD_CYCLES + 10; i++) begin
                @(negedge radio_clk);
                if (first >= 0) begin
                    check_pps("o_pps", o_pps, ((i - first) % PPS_PERIOD_CYCLES) == 0);
                end else if (o_pps) begin
                    first = i;
                end
            end
            if (first < 0 || first >= PPS_PERIOD_CYCLES) begin
                fail_run("Internal PPS gave no pulse within one period");
            end
            @(posedge radio_clk);
            #2;
        end else begin
            for (int i = 0; i < 64; i++) begin
                i_pps_ext = ext_bits[i];
                i_pps_int = gps_bits[i];
                @(negedge radio_clk);
                if (src == PPS_OFF) begin
                    check_pps("o_pps", o_pps, 1'b0);
                end else if (i >= 2) begin
                    check_pps("o_pps", o_pps, (src == PPS_EXT) ? ext_bits[i-2] : gps_bits[i-2]);
                end
                @(posedge radio_clk);
                #2;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Response and radio 0 monitors
    ////////////////////////////////////////////////////////////////////////////
    // Each word seen here transfers on the following rising edge
    always @(negedge radio_clk) begin
        if (!bus_rst && o_resp_tvalid && i_resp_tready) begin
            if (!rx_in_pkt) rx_radio = (o_resp_tdata[7:0] == R0_RESP_SID);
            check_last("o_resp_tlast", o_resp_tlast, rx_in_pkt);
            if (rx_radio) begin
                if (exp_radio.size() == 0) fail_run("Radio response arrived with none outstanding");
                check_word("o_resp_tdata", o_resp_tdata, exp_radio.pop_front());
            end else begin
                if (exp_local.size() == 0) fail_run("Local response arrived with none outstanding");
                check_word("o_resp_tdata", o_resp_tdata, exp_local.pop_front());
                if (rx_in_pkt) check_data("o_misc_outs", o_misc_outs, m_misc);
            end
            rx_in_pkt = !rx_in_pkt;
        end
    end

    always @(negedge radio_clk) begin
        if (!bus_rst && o_r0_ctrl_tvalid && i_r0_ctrl_tready) begin
            if (exp_r0.size() == 0) fail_run("A local packet was routed to radio 0");
            check_word("o_r0_ctrl_tdata", o_r0_ctrl_tdata, exp_r0.pop_front());
            check_last("o_r0_ctrl_tlast", o_r0_ctrl_tlast, r0_in_pkt);
            ret_q.push_back(r0_in_pkt ? o_r0_ctrl_tdata : {o_r0_ctrl_tdata[63:8], R0_RESP_SID});
            r0_in_pkt = !r0_in_pkt;
        end
    end

    // Radio reply word taken at the coming rising edge
    always @(negedge radio_clk) begin
        ret_taken = i_r0_resp_tvalid && o_r0_resp_tready;
    end

    // Back-pressure and radio replies, all random draws in one process
    always @(posedge radio_clk) begin
        #2;
        i_resp_tready    = ($random(seed) & 3) != 0;
        i_r0_ctrl_tready = ($random(seed) & 3) != 0;
        if (ret_taken) begin
            i_r0_resp_tvalid = 1'b0;
            ret_last         = !ret_last;
        end
        if (!i_r0_resp_tvalid && ret_q.size() != 0 && ($random(seed) & 1) != 0) begin
            i_r0_resp_tdata  = ret_q.pop_front();
            i_r0_resp_tlast  = ret_last;
            i_r0_resp_tvalid = 1'b1;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 20);
        fail_run("Watchdog expired before all responses and PPS checks completed");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        sid_t      sid;
        set_addr_t addr;
        seed             = 32'h6183_6d69;
        bus_rst          = 1'b1;
        i_ctrl_tdata     = '0;
        i_ctrl_tlast     = 1'b0;
        i_ctrl_tvalid    = 1'b0;
        i_resp_tready    = 1'b0;
        i_r0_ctrl_tready = 1'b0;
        i_r0_resp_tdata  = '0;
        i_r0_resp_tlast  = 1'b0;
        i_r0_resp_tvalid = 1'b0;
        i_pps_int        = 1'b0;
        i_pps_ext        = 1'b0;
        i_lock_signals   = 2'b00;
        m_misc           = '0;
        m_rb_sel         = '0;
        m_gpsdo          = '0;
        rx_in_pkt        = 1'b0;
        rx_radio         = 1'b0;
        r0_in_pkt        = 1'b0;
        ret_last         = 1'b0;
        ret_taken        = 1'b0;

        for (int i = 0; i < NUM_RAND; i++) begin
            sid = sid_t'($random(seed));
            if (($random(seed) & 1) != 0) sid[7:4] = 4'h1;     // Bias toward radio 0
            case ($random(seed) & 7)
                0, 1:    addr = SR_CORE_MISC;
                2, 3:    addr = SR_CORE_READBACK;
                4:       addr = SR_CORE_GPSDO_ST;
                5:       addr = SR_CORE_PPS_SEL;
                default: addr = set_addr_t'($random(seed));     // Mostly unmapped
            endcase
            pkt_hdr[i][63:32] = $random(seed);
            pkt_hdr[i][31:0]  = $random(seed);
            pkt_hdr[i][7:0]   = sid;
            pkt_cmd[i][63:32] = $random(seed);
            pkt_cmd[i][31:0]  = $random(seed);
            pkt_cmd[i][39:32] = addr;
            pkt_lock[i]       = 2'($random(seed));
        end
        i_rb_misc        = $random(seed);
        ext_bits[31:0]   = $random(seed);
        ext_bits[63:32]  = $random(seed);
        gps_bits[31:0]   = $random(seed);
        gps_bits[63:32]  = $random(seed);

        repeat (2) @(posedge radio_clk);
        #2;
        bus_rst = 1'b0;

        // Signature, then GPSDO status through readback select 1
        send_pkt({56'h0, L0_CTRL_SID}, {24'h0, 8'hff, 32'h1234_5678}, 2'b00);
        send_pkt({56'h0, L0_CTRL_SID}, {24'h0, SR_CORE_GPSDO_ST, 32'h0000_00a5}, 2'b00);
        send_pkt({56'h0, L0_CTRL_SID}, {24'h0, SR_CORE_READBACK, 32'h0000_0001}, 2'b00);

        for (int i = 0; i < NUM_RAND; i++) begin
            send_pkt(pkt_hdr[i], pkt_cmd[i], pkt_lock[i]);
        end
        wait_all_idle();

        run_pps(PPS_EXT);
        run_pps(PPS_GPSDO);
        run_pps(PPS_INT);
        run_pps(PPS_OFF);
        wait_all_idle();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: logic/b200_core.sv
// Control and timing core, one clock domain only.
// Radio 0 itself lives outside; its control and response streams are ports.
`timescale 1ns/1ns

module b200_core import core_pkg::*; (
    input  logic       radio_clk,
    input  logic       bus_rst,

    // Host control in, responses out
    input  ctrl_word_t i_ctrl_tdata,
    input  logic       i_ctrl_tlast,
    input  logic       i_ctrl_tvalid,
    output logic       o_ctrl_tready,
    output ctrl_word_t o_resp_tdata,
    output logic       o_resp_tlast,
    output logic       o_resp_tvalid,
    input  logic       i_resp_tready,

    // Radio 0 control port
    output ctrl_word_t o_r0_ctrl_tdata,
    output logic       o_r0_ctrl_tlast,
    output logic       o_r0_ctrl_tvalid,
    input  logic       i_r0_ctrl_tready,
    input  ctrl_word_t i_r0_resp_tdata,
    input  logic       i_r0_resp_tlast,
    input  logic       i_r0_resp_tvalid,
    output logic       o_r0_resp_tready,

    input  logic       i_pps_int,       // GPSDO PPS
    input  logic       i_pps_ext,
    input  logic [1:0] i_lock_signals,
    input  set_data_t  i_rb_misc,
    output set_data_t  o_misc_outs,
    output logic       o_pps
);

    ctrl_word_t l0_ctrl_tdata;
    logic       l0_ctrl_tlast, l0_ctrl_tvalid, l0_ctrl_tready;
    ctrl_word_t l0_resp_tdata;
    logic       l0_resp_tlast, l0_resp_tvalid, l0_resp_tready;

    logic       set_stb;
    set_addr_t  set_addr;
    set_data_t  set_data;
    ctrl_word_t rb_data;
    pps_src_t   pps_sel;

    ctrl_demux demux_for_ctrl (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_tdata(i_ctrl_tdata), .i_tlast(i_ctrl_tlast), .i_tvalid(i_ctrl_tvalid),
        .o_tready(o_ctrl_tready),
        .o_r0_tdata(o_r0_ctrl_tdata), .o_r0_tlast(o_r0_ctrl_tlast),
        .o_r0_tvalid(o_r0_ctrl_tvalid), .i_r0_tready(i_r0_ctrl_tready),
        .o_l0_tdata(l0_ctrl_tdata), .o_l0_tlast(l0_ctrl_tlast),
        .o_l0_tvalid(l0_ctrl_tvalid), .i_l0_tready(l0_ctrl_tready)
    );

    ctrl_proc local_ctrl_proc (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_ctrl_tdata(l0_ctrl_tdata), .i_ctrl_tlast(l0_ctrl_tlast),
        .i_ctrl_tvalid(l0_ctrl_tvalid), .o_ctrl_tready(l0_ctrl_tready),
        .o_resp_tdata(l0_resp_tdata), .o_resp_tlast(l0_resp_tlast),
        .o_resp_tvalid(l0_resp_tvalid), .i_resp_tready(l0_resp_tready),
        .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
        .i_rb_data(rb_data)
    );

    core_settings settings (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
        .i_lock_signals(i_lock_signals), .i_rb_misc(i_rb_misc),
        .o_misc_outs(o_misc_outs), .o_pps_sel(pps_sel), .o_rb_data(rb_data)
    );

    pps_select pps_mux (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext), .i_pps_sel(pps_sel),
        .o_pps(o_pps)
    );

    // Input 0 local responses, input 1 radio 0 responses
    resp_mux mux_for_resp (
        .radio_clk(radio_clk), .bus_rst(bus_rst),
        .i0_tdata(l0_resp_tdata), .i0_tlast(l0_resp_tlast),
        .i0_tvalid(l0_resp_tvalid), .o0_tready(l0_resp_tready),
        .i1_tdata(i_r0_resp_tdata), .i1_tlast(i_r0_resp_tlast),
        .i1_tvalid(i_r0_resp_tvalid), .o1_tready(o_r0_resp_tready),
        .o_tdata(o_resp_tdata), .o_tlast(o_resp_tlast), .o_tvalid(o_resp_tvalid),
        .i_tready(i_resp_tready)
    );

endmodule

// File: logic/pps_select.sv
// PPS source selection; external and GPSDO pulses come out two cycles late.
// The internal PPS is a one-cycle pulse every PPS_PERIOD_CYCLES.
`timescale 1ns/1ns

module pps_select import core_pkg::*; (
    input  logic     radio_clk,
    input  logic     bus_rst,
    input  logic     i_pps_int,     // From the GPSDO
    input  logic     i_pps_ext,     // Front panel input
    input  pps_src_t i_pps_sel,
    output logic     o_pps
);

    logic [PPS_CNT_W-1:0] pps_cnt;
    logic                 int_pps;
    logic [1:0]           gpsdo_sync;
    logic [1:0]           ext_sync;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            pps_cnt    <= '0;
            int_pps    <= 1'b0;
            gpsdo_sync <= '0;
            ext_sync   <= '0;
        end else begin
            if (pps_cnt == PPS_CNT_W'(PPS_PERIOD_CYCLES - 1)) begin
                pps_cnt <= '0;
                int_pps <= 1'b1;
            end else begin
                pps_cnt <= pps_cnt + 1'b1;
                int_pps <= 1'b0;
            end
            gpsdo_sync <= {gpsdo_sync[0], i_pps_int};
            ext_sync   <= {ext_sync[0], i_pps_ext};
        end
    end

    always_comb begin
        case (i_pps_sel)
            PPS_GPSDO: o_pps = gpsdo_sync[1];
            PPS_EXT:   o_pps = ext_sync[1];
            PPS_INT:   o_pps = int_pps;
            default:   o_pps = 1'b0;       // PPS_OFF
        endcase
    end

endmodule

// File: logic/core_settings.sv
// Core settings registers and the readback word for the control processor.
// The GPSDO status register has no reset and must be written before use.
`timescale 1ns/1ns

module core_settings import core_pkg::*; (
    input  logic       radio_clk,
    input  logic       bus_rst,
    input  logic       i_set_stb,
    input  set_addr_t  i_set_addr,
    input  set_data_t  i_set_data,
    input  logic [1:0] i_lock_signals,   // Front-end lock, asynchronous
    input  set_data_t  i_rb_misc,
    output set_data_t  o_misc_outs,
    output pps_src_t   o_pps_sel,
    output ctrl_word_t o_rb_data
);

    rb_sel_t    rb_sel;
    logic [7:0] gpsdo_st;
    logic [1:0] lock_meta;
    logic [1:0] lock_sync;

    ////////////////////////////////////////////////////////////////////////////
    // Settings registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            o_misc_outs <= '0;
            rb_sel      <= '0;
            o_pps_sel   <= PPS_GPSDO;
        end else if (i_set_stb) begin
            case (i_set_addr)
                SR_CORE_MISC:     o_misc_outs <= i_set_data;
                SR_CORE_READBACK: rb_sel      <= i_set_data[1:0];
                SR_CORE_PPS_SEL:  o_pps_sel   <= pps_src_t'(i_set_data[1:0]);
                default: ;                    // Unknown or unreset addresses
            endcase
        end
    end

    // Keeps its value across reset
    always_ff @(posedge radio_clk) begin
        if (i_set_stb && i_set_addr == SR_CORE_GPSDO_ST) begin
            gpsdo_st <= i_set_data[7:0];
        end
    end

    // Two-flop synchroniser on the lock bits
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            lock_meta <= '0;
            lock_sync <= '0;
        end else begin
            lock_meta <= i_lock_signals;
            lock_sync <= lock_meta;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (rb_sel)
            2'd0:    o_rb_data = {COMPAT_SIGNATURE, COMPAT_MAJOR, COMPAT_MINOR};
            2'd1:    o_rb_data = {16'h0, RADIO_STATUS, gpsdo_st, i_rb_misc};
            2'd2:    o_rb_data = {62'h0, lock_sync};
            default: o_rb_data = {32'h0, o_misc_outs};
        endcase
    end

endmodule

// File: logic/ctrl_proc.sv
// Local control processor for two-word settings packets.
// Each write gets a response of the request header plus the readback word.
// Only one packet is in flight; the next one waits for the response tlast.
`timescale 1ns/1ns

module ctrl_proc import core_pkg::*; (
    input  logic       radio_clk,
    input  logic       bus_rst,
    input  ctrl_word_t i_ctrl_tdata,
    input  logic       i_ctrl_tlast,
    input  logic       i_ctrl_tvalid,
    output logic       o_ctrl_tready,
    output ctrl_word_t o_resp_tdata,
    output logic       o_resp_tlast,
    output logic       o_resp_tvalid,
    input  logic       i_resp_tready,
    output logic       o_set_stb,
    output set_addr_t  o_set_addr,
    output set_data_t  o_set_data,
    input  ctrl_word_t i_rb_data
);

    typedef enum logic [2:0] {
        ST_HDR,
        ST_CMD,
        ST_WRITE,
        ST_CAPTURE,
        ST_RESP_HDR,
        ST_RESP_PAY
    } state_t;

    state_t     state;
    ctrl_word_t hdr_q;      // Echoed back as the response header
    ctrl_word_t rb_q;
    logic       ctrl_xfer;
    logic       resp_xfer;

    assign o_ctrl_tready = (state == ST_HDR) || (state == ST_CMD);
    assign ctrl_xfer     = i_ctrl_tvalid && o_ctrl_tready;
    assign resp_xfer     = o_resp_tvalid && i_resp_tready;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            state <= ST_HDR;
        end else begin
            case (state)
                ST_HDR:      if (ctrl_xfer) state <= ST_CMD;
                ST_CMD:      if (ctrl_xfer) state <= ST_WRITE;
                ST_WRITE:    state <= ST_CAPTURE;       // Strobe cycle
                ST_CAPTURE:  state <= ST_RESP_HDR;      // Readback now sees the write
                ST_RESP_HDR: if (resp_xfer) state <= ST_RESP_PAY;
                ST_RESP_PAY: if (resp_xfer) state <= ST_HDR;
                default:     state <= ST_HDR;
            endcase
        end
    end

    always_ff @(posedge radio_clk) begin
        if (state == ST_HDR && ctrl_xfer) begin
            hdr_q <= i_ctrl_tdata;
        end
        if (state == ST_CMD && ctrl_xfer) begin
            o_set_addr <= i_ctrl_tdata[39:32];
            o_set_data <= i_ctrl_tdata[31:0];
        end
        if (state == ST_CAPTURE) begin
            rb_q <= i_rb_data;
        end
    end

    assign o_set_stb     = (state == ST_WRITE);
    assign o_resp_tvalid = (state == ST_RESP_HDR) || (state == ST_RESP_PAY);
    assign o_resp_tlast  = (state == ST_RESP_PAY);
    assign o_resp_tdata  = (state == ST_RESP_PAY) ? rb_q : hdr_q;

    // Packets from the demux carry tlast on the command word and nowhere else
    a_tlast_on_cmd: assert property (@(posedge radio_clk) disable iff (bus_rst)
        ctrl_xfer |-> (i_ctrl_tlast == (state == ST_CMD)));

endmodule

// File: logic/resp_mux.sv
// Two-input packet mux with round-robin arbitration per packet.
// A granted packet owns the output until its tlast; one cycle of latency.
`timescale 1ns/1ns

module resp_mux import core_pkg::*; (
    input  logic       radio_clk,
    input  logic       bus_rst,
    input  ctrl_word_t i0_tdata,
    input  logic       i0_tlast,
    input  logic       i0_tvalid,
    output logic       o0_tready,
    input  ctrl_word_t i1_tdata,
    input  logic       i1_tlast,
    input  logic       i1_tvalid,
    output logic       o1_tready,
    output ctrl_word_t o_tdata,
    output logic       o_tlast,
    output logic       o_tvalid,
    input  logic       i_tready
);

    logic busy;       // Inside a packet
    logic grant_q;    // Current owner, or last winner when idle
    logic sel;
    logic can_load;
    logic xfer;
    logic sel_last;

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (busy) begin
            sel = grant_q;
        end else if (i0_tvalid && i1_tvalid) begin
            sel = !grant_q;               // Both waiting so alternate
        end else begin
            sel = i1_tvalid;
        end
    end

    assign can_load  = !o_tvalid || i_tready;
    assign o0_tready = can_load && !sel;
    assign o1_tready = can_load && sel;
    assign xfer      = sel ? (i1_tvalid && o1_tready) : (i0_tvalid && o0_tready);
    assign sel_last  = sel ? i1_tlast : i0_tlast;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            busy     <= 1'b0;
            grant_q  <= 1'b1;             // Input 0 wins the first contest
            o_tvalid <= 1'b0;
        end else begin
            if (xfer) begin
                busy     <= !sel_last;
                grant_q  <= sel;
                o_tvalid <= 1'b1;
            end else if (i_tready) begin
                o_tvalid <= 1'b0;
            end
        end
    end

    // Output register
    always_ff @(posedge radio_clk) begin
        if (xfer) begin
            o_tdata <= sel ? i1_tdata : i0_tdata;
            o_tlast <= sel_last;
        end
    end

    // Grant is frozen from the first word until tlast goes through
    a_grant_held: assert property (@(posedge radio_clk) disable iff (bus_rst)
        (busy && !(xfer && sel_last)) |=> (busy && grant_q == $past(grant_q)));

endmodule

// File: logic/ctrl_demux.sv
// Routes whole packets by header SID; radio 0 SIDs go out, the rest stay local.
// One register stage, so every word is delayed by one cycle.
`timescale 1ns/1ns

module ctrl_demux import core_pkg::*; (
    input  logic       radio_clk,
    input  logic       bus_rst,
    input  ctrl_word_t i_tdata,
    input  logic       i_tlast,
    input  logic       i_tvalid,
    output logic       o_tready,
    output ctrl_word_t o_r0_tdata,
    output logic       o_r0_tlast,
    output logic       o_r0_tvalid,
    input  logic       i_r0_tready,
    output ctrl_word_t o_l0_tdata,
    output logic       o_l0_tlast,
    output logic       o_l0_tvalid,
    input  logic       i_l0_tready
);

    sid_t       hdr_sid;
    logic       in_pkt;       // Past the header, waiting for tlast
    logic       dst_r0;       // Destination of the incoming word
    logic       dst_r0_q;     // Destination of the held word and its packet
    logic       out_valid;
    logic       out_last;
    ctrl_word_t out_data;
    logic       out_ready;
    logic       accept;

    assign hdr_sid   = i_tdata[7:0];
    assign dst_r0    = in_pkt ? dst_r0_q : ((hdr_sid & SID_MASK) == R0_CTRL_SID);
    assign out_ready = dst_r0_q ? i_r0_tready : i_l0_tready;
    assign o_tready  = !out_valid || out_ready;   // Empty or draining this cycle
    assign accept    = i_tvalid && o_tready;

    always_ff @(posedge radio_clk) begin
        if (bus_rst) begin
            in_pkt    <= 1'b0;
            dst_r0_q  <= 1'b0;
            out_valid <= 1'b0;
        end else if (accept) begin
            in_pkt    <= !i_tlast;
            dst_r0_q  <= dst_r0;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge radio_clk) begin
        if (accept) begin
            out_data <= i_tdata;
            out_last <= i_tlast;
        end
    end

    assign o_r0_tdata  = out_data;
    assign o_r0_tlast  = out_last;
    assign o_r0_tvalid = out_valid && dst_r0_q;
    assign o_l0_tdata  = out_data;
    assign o_l0_tlast  = out_last;
    assign o_l0_tvalid = out_valid && !dst_r0_q;

    // A stalled word stays put on its port until taken
    a_r0_hold: assert property (@(posedge radio_clk) disable iff (bus_rst)
        (o_r0_tvalid && !i_r0_tready) |=>
            (o_r0_tvalid && $stable(o_r0_tdata) && $stable(o_r0_tlast)));
    a_l0_hold: assert property (@(posedge radio_clk) disable iff (bus_rst)
        (o_l0_tvalid && !i_l0_tready) |=>
            (o_l0_tvalid && $stable(o_l0_tdata) && $stable(o_l0_tlast)));

endmodule

// File: logic/core_pkg.sv
// Shared types and constants for the single-clock control core.
// Control packets are always two 64-bit words, header first.
// PPS_PERIOD_CYCLES is short for simulation and is far below one second.
package core_pkg;

    typedef logic [63:0] ctrl_word_t;   // One stream word
    typedef logic [7:0]  sid_t;         // Stream ID, header bits 7:0
    typedef logic [7:0]  set_addr_t;
    typedef logic [31:0] set_data_t;
    typedef logic [1:0]  rb_sel_t;

    typedef enum logic [1:0] {
        PPS_GPSDO = 2'd0,
        PPS_EXT   = 2'd1,
        PPS_INT   = 2'd2,
        PPS_OFF   = 2'd3
    } pps_src_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stream routing
    ////////////////////////////////////////////////////////////////////////////
    localparam sid_t SID_MASK    = 8'hf0;
    localparam sid_t R0_CTRL_SID = 8'h10;   // Radio 0 control
    localparam sid_t L0_CTRL_SID = 8'h40;   // Local processor

    ////////////////////////////////////////////////////////////////////////////
    // Settings bus map
    ////////////////////////////////////////////////////////////////////////////
    localparam set_addr_t SR_CORE_MISC     = 8'd16;
    localparam set_addr_t SR_CORE_READBACK = 8'd32;
    localparam set_addr_t SR_CORE_GPSDO_ST = 8'd40;
    localparam set_addr_t SR_CORE_PPS_SEL  = 8'd48;

    // Readback word 0 contents
    localparam logic [31:0] COMPAT_SIGNATURE = 32'hACE0BA5E;
    localparam logic [15:0] COMPAT_MAJOR     = 16'h0007;
    localparam logic [15:0] COMPAT_MINOR     = 16'h0000;
    localparam logic [7:0]  RADIO_STATUS     = 8'h01;  // One radio fitted

    ////////////////////////////////////////////////////////////////////////////
    // Internal PPS
    ////////////////////////////////////////////////////////////////////////////
    localparam int PPS_PERIOD_CYCLES = 200;
    localparam int PPS_CNT_W         = $clog2(PPS_PERIOD_CYCLES);

endpackage
